//--- design/tag_pkg.sv
`default_nettype none

package tag_pkg;

  // Tag array geometry
  localparam int TAG_W   = 10;
  localparam int INDEX_W = 9;
  // One way is a valid bit plus its tag
  localparam int WAY_W   = TAG_W + 1;
  // Two ways per set word
  localparam int SET_W   = 2 * WAY_W;

  // Request operation codes
  typedef enum logic [1:0] {
    OP_LOOKUP = 2'd0,
    OP_FILL   = 2'd1,
    OP_INVAL  = 2'd2
  } tag_op_t;

  // Single way entry, valid in the top bit
  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
  } way_entry_t;

  // Set word, way 1 in bits 21..11 and way 0 in bits 10..0
  typedef struct packed {
    way_entry_t way1;
    way_entry_t way0;
  } tag_set_t;

  // Request payload carried with req
  typedef struct packed {
    tag_op_t            op;
    logic [TAG_W-1:0]   tag;
    logic [INDEX_W-1:0] index;
  } tag_req_t;

  // Response payload, valid while ack is high
  typedef struct packed {
    logic             hit;
    logic             way;
    logic             evicted;
    logic [TAG_W-1:0] evict_tag;
  } tag_resp_t;

endpackage

`default_nettype wire

//--- design/fpga_ram.sv
`timescale 1ns/1ps
`default_nettype none

module fpga_ram #(
  parameter int DATA_WIDTH = 11,
  parameter int ADDR_WIDTH = 9
) (
  input  wire logic                  CLK,
  input  wire logic [ADDR_WIDTH-1:0] addr,
  input  wire logic [DATA_WIDTH-1:0] din,
  input  wire logic                  wen,
  output logic      [DATA_WIDTH-1:0] dout
);

  localparam int DEPTH = 1 << ADDR_WIDTH;

  // Storage array
  logic [DATA_WIDTH-1:0] mem [0:DEPTH-1];
  // Read address of the last edge
  logic [ADDR_WIDTH-1:0] addr_q;

  // Write and address capture on the same edge
  always_ff @(posedge CLK) begin
    if (wen) begin
      mem[addr] <= din;
    end
    addr_q <= addr;
  end

  // Read from the registered address
  // A write to the same word shows its new data after the edge
  assign dout = mem[addr_q];

endmodule

`default_nettype wire

//--- design/spsram_512x22.sv
`timescale 1ns/1ps
`default_nettype none

module spsram_512x22
  import tag_pkg::*;
#(
  parameter int ADDR_WIDTH = 9
) (
  input  wire logic                  CLK,
  input  wire logic [ADDR_WIDTH-1:0] A,
  input  wire logic                  CEN,
  input  wire logic [SET_W-1:0]      D,
  input  wire logic                  GWEN,
  input  wire logic [SET_W-1:0]      WEN,
  output logic      [SET_W-1:0]      Q
);

  // Number of 11-bit lanes in the word
  localparam int LANES = SET_W / WAY_W;

  // Address captured on the last enabled edge
  logic [ADDR_WIDTH-1:0] addr_hold;
  // Address seen by both slices
  logic [ADDR_WIDTH-1:0] addr;

  // Hold the address while the chip is enabled
  always_ff @(posedge CLK) begin
    if (!CEN) begin
      addr_hold <= A;
    end
  end

  // Disabled chip replays the held address, so Q stays put
  assign addr = CEN ? addr_hold : A;

  // One slice per lane
  for (genvar i = 0; i < LANES; i++) begin : g_lane
    logic [WAY_W-1:0] lane_din;
    logic [WAY_W-1:0] lane_dout;
    logic             lane_wen;

    // Lane slice of the data word
    assign lane_din = D[i*WAY_W +: WAY_W];

    // Lane write needs chip, global and lane enables all low
    // Top bit of the lane stands for the whole lane
    assign lane_wen = !CEN && !GWEN && !WEN[i*WAY_W + WAY_W - 1];

    fpga_ram #(
      .DATA_WIDTH (WAY_W),
      .ADDR_WIDTH (ADDR_WIDTH)
    ) u_ram (
      .CLK  (CLK),
      .addr (addr),
      .din  (lane_din),
      .wen  (lane_wen),
      .dout (lane_dout)
    );

    // Reassemble the output word
    assign Q[i*WAY_W +: WAY_W] = lane_dout;

    // Bit writes inside a lane are not supported
    a_lane_wen_uniform: assert property (
      @(posedge CLK) (!CEN && !GWEN) |->
        (&WEN[i*WAY_W +: WAY_W]) || !(|WEN[i*WAY_W +: WAY_W])
    ) else $error("spsram_512x22: partial write mask in lane %0d", i);
  end

endmodule

`default_nettype wire

//--- design/tag_lookup_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tag_lookup_ctrl
  import tag_pkg::*;
(
  input  wire logic               CLK,
  input  wire logic               reset,
  // Requester side, four-phase handshake
  input  wire logic               req,
  input  wire tag_req_t           req_data,
  output logic                    ack,
  output tag_resp_t               resp,
  // Macro side, active-low controls
  output logic      [INDEX_W-1:0] sram_a,
  output logic                    sram_cen,
  output tag_set_t                sram_d,
  output logic                    sram_gwen,
  output logic      [SET_W-1:0]   sram_wen,
  input  wire tag_set_t           sram_q
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_READ,
    S_CMP,
    S_WRITE,
    S_ACK
  } state_t;

  state_t     state;
  // Request captured at the start of the transaction
  tag_req_t   req_q;
  // Global round-robin victim for full sets
  logic       victim_ptr;

  // Compare results
  logic       hit0;
  logic       hit1;
  logic       hit_any;
  logic       hit_way;
  // Victim selection
  logic       victim;
  logic       victim_full;
  way_entry_t victim_entry;
  // Write-back data
  logic       tgt_way;
  logic       need_write;
  way_entry_t new_entry;
  tag_set_t   new_set;
  logic [SET_W-1:0] wr_mask;
  tag_resp_t  resp_next;

  // Index goes straight out, the macro holds it between accesses
  assign sram_a = req_q.index;

  // Tag compare and victim choice on the read data
  always_comb begin
    hit0    = sram_q.way0.valid && (sram_q.way0.tag == req_q.tag);
    hit1    = sram_q.way1.valid && (sram_q.way1.tag == req_q.tag);
    hit_any = hit0 || hit1;
    // Way 0 wins if both match
    hit_way = !hit0;

    // Free way first, then the pointer
    if (!sram_q.way0.valid) begin
      victim      = 1'b0;
      victim_full = 1'b0;
    end else if (!sram_q.way1.valid) begin
      victim      = 1'b1;
      victim_full = 1'b0;
    end else begin
      victim      = victim_ptr;
      victim_full = 1'b1;
    end
    victim_entry = victim ? sram_q.way1 : sram_q.way0;

    // Fill writes the victim, invalidate writes the matching way
    tgt_way = (req_q.op == OP_FILL) ? victim : hit_way;

    // New entry, cleared for invalidate
    new_entry.valid = (req_q.op == OP_FILL);
    new_entry.tag   = (req_q.op == OP_FILL) ? req_q.tag : '0;

    // Untouched way keeps its read value
    new_set = sram_q;
    if (tgt_way) begin
      new_set.way1 = new_entry;
    end else begin
      new_set.way0 = new_entry;
    end

    // Active-low mask over the target lane only
    wr_mask = tgt_way ? {{WAY_W{1'b0}}, {WAY_W{1'b1}}}
                      : {{WAY_W{1'b1}}, {WAY_W{1'b0}}};

    // Write only on fill miss or invalidate hit
    need_write = ((req_q.op == OP_FILL) && !hit_any) ||
                 ((req_q.op == OP_INVAL) && hit_any);

    // Response fields
    resp_next = '0;
    case (req_q.op)
      OP_LOOKUP, OP_INVAL: begin
        resp_next.hit = hit_any;
        resp_next.way = hit_any && hit_way;
      end
      OP_FILL: begin
        resp_next.hit     = hit_any;
        // Present way on a hit, else the victim
        resp_next.way     = hit_any ? hit_way : victim;
        resp_next.evicted = !hit_any && victim_full;
        if (!hit_any && victim_full) begin
          resp_next.evict_tag = victim_entry.tag;
        end
      end
      default: resp_next = '0;
    endcase
  end

  // Control state
  always_ff @(posedge CLK) begin
    if (reset) begin
      state      <= S_IDLE;
      ack        <= 1'b0;
      sram_cen   <= 1'b1;
      sram_gwen  <= 1'b1;
      sram_wen   <= '1;
      victim_ptr <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          // Issue the set read
          if (req) begin
            sram_cen  <= 1'b0;
            sram_gwen <= 1'b1;
            state     <= S_READ;
          end
        end
        S_READ: begin
          // Read taken this edge, Q valid after it
          sram_cen <= 1'b1;
          state    <= S_CMP;
        end
        S_CMP: begin
          if (need_write) begin
            sram_cen  <= 1'b0;
            sram_gwen <= 1'b0;
            sram_wen  <= wr_mask;
            state     <= S_WRITE;
            // Pointer moves only when a valid line is replaced
            if ((req_q.op == OP_FILL) && victim_full) begin
              victim_ptr <= ~victim_ptr;
            end
          end else begin
            ack   <= 1'b1;
            state <= S_ACK;
          end
        end
        S_WRITE: begin
          // Write taken this edge
          sram_cen  <= 1'b1;
          sram_gwen <= 1'b1;
          sram_wen  <= '1;
          ack       <= 1'b1;
          state     <= S_ACK;
        end
        S_ACK: begin
          // Hold until the requester lets go
          if (!req) begin
            ack   <= 1'b0;
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Payload registers
  always_ff @(posedge CLK) begin
    if ((state == S_IDLE) && req) begin
      req_q <= req_data;
    end
    if (state == S_CMP) begin
      resp   <= resp_next;
      sram_d <= new_set;
    end
  end

  // ack held for as long as req
  a_ack_hold: assert property (
    @(posedge CLK) disable iff (reset) (ack && req) |=> ack
  ) else $error("tag_lookup_ctrl: ack fell while req high");

  // Lookups never touch the array
  a_no_lookup_write: assert property (
    @(posedge CLK) disable iff (reset)
      (!sram_cen && !sram_gwen) |-> (req_q.op != OP_LOOKUP)
  ) else $error("tag_lookup_ctrl: write issued for a lookup");

  // Requester keeps the payload until ack
  a_req_stable: assert property (
    @(posedge CLK) disable iff (reset)
      (req && !ack) |=> (!req || $stable(req_data))
  ) else $error("tag_lookup_ctrl: req_data changed before ack");

endmodule

`default_nettype wire

//--- design/tag_array_top.sv
`timescale 1ns/1ps
`default_nettype none

module tag_array_top
  import tag_pkg::*;
(
  input  wire logic     CLK,
  input  wire logic     reset,
  // Four-phase request port
  input  wire logic     req,
  input  wire tag_req_t req_data,
  output logic          ack,
  output tag_resp_t     resp
);

  // Macro port nets
  logic [INDEX_W-1:0] sram_a;
  logic               sram_cen;
  tag_set_t           sram_d;
  logic               sram_gwen;
  logic [SET_W-1:0]   sram_wen;
  tag_set_t           sram_q;

  // Request FSM and compare logic
  tag_lookup_ctrl u_ctrl (
    .CLK       (CLK),
    .reset     (reset),
    .req       (req),
    .req_data  (req_data),
    .ack       (ack),
    .resp      (resp),
    .sram_a    (sram_a),
    .sram_cen  (sram_cen),
    .sram_d    (sram_d),
    .sram_gwen (sram_gwen),
    .sram_wen  (sram_wen),
    .sram_q    (sram_q)
  );

  // One set per address, one way per lane
  spsram_512x22 #(
    .ADDR_WIDTH (INDEX_W)
  ) u_sram (
    .CLK  (CLK),
    .A    (sram_a),
    .CEN  (sram_cen),
    .D    (sram_d),
    .GWEN (sram_gwen),
    .WEN  (sram_wen),
    .Q    (sram_q)
  );

endmodule

`default_nettype wire

//--- tests/tag_array_checks.svh
`ifndef TAG_ARRAY_CHECKS_SVH
`define TAG_ARRAY_CHECKS_SVH

// Model of every set, cleared before the first request
tag_set_t model_sets [0:(1<<INDEX_W)-1];
// Global victim pointer, zero after reset
logic     model_ptr = 1'b0;

int check_count = 0;
int error_count = 0;

// Expected response for one request, model updated as a side effect
function automatic tag_resp_t ref_apply(input tag_req_t r);
  tag_set_t  cur;
  tag_resp_t exp_resp;
  logic      h0;
  logic      h1;
  logic      w;
  cur      = model_sets[r.index];
  exp_resp = '0;
  h0 = cur.way0.valid && (cur.way0.tag == r.tag);
  h1 = cur.way1.valid && (cur.way1.tag == r.tag);
  case (r.op)
    OP_FILL: begin
      exp_resp.hit = h0 || h1;
      if (h0 || h1) begin
        // Already present, way 0 first
        exp_resp.way = !h0;
      end else begin
        // Free way 0, then free way 1, then the pointer
        if (!cur.way0.valid) begin
          w = 1'b0;
        end else if (!cur.way1.valid) begin
          w = 1'b1;
        end else begin
          w                  = model_ptr;
          exp_resp.evicted   = 1'b1;
          exp_resp.evict_tag = w ? cur.way1.tag : cur.way0.tag;
          model_ptr          = !model_ptr;
        end
        exp_resp.way = w;
        if (w) begin
          cur.way1.valid = 1'b1;
          cur.way1.tag   = r.tag;
        end else begin
          cur.way0.valid = 1'b1;
          cur.way0.tag   = r.tag;
        end
      end
    end
    OP_INVAL: begin
      exp_resp.hit = h0 || h1;
      exp_resp.way = !h0 && h1;
      // Cleared entry is all zero
      if (h0) begin
        cur.way0 = '0;
      end else if (h1) begin
        cur.way1 = '0;
      end
    end
    default: begin
      exp_resp.hit = h0 || h1;
      exp_resp.way = !h0 && h1;
    end
  endcase
  model_sets[r.index] = cur;
  return exp_resp;
endfunction

task automatic check_resp(input tag_resp_t exp_resp, input tag_resp_t act, input string what);
  check_count++;
  if (exp_resp !== act) begin
    error_count++;
    $display("Error at %0t: %s: resp expected %h, got %h", $time, what, exp_resp, act);
  end
endtask

task automatic check_hit(input logic exp_hit, input logic act, input string what);
  check_count++;
  if (exp_hit !== act) begin
    error_count++;
    $display("Error at %0t: %s: hit expected %b, got %b", $time, what, exp_hit, act);
  end
endtask

task automatic check_way(input logic exp_way, input logic act, input string what);
  check_count++;
  if (exp_way !== act) begin
    error_count++;
    $display("Error at %0t: %s: way expected %b, got %b", $time, what, exp_way, act);
  end
endtask

task automatic check_ack(input logic exp_ack, input logic act, input string what);
  check_count++;
  if (exp_ack !== act) begin
    error_count++;
    $display("Error at %0t: %s: ack expected %b, got %b", $time, what, exp_ack, act);
  end
endtask

`endif

//--- tests/tag_array_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tag_array_tb
  import tag_pkg::*;
();

  localparam int RESET_CYCLES = 10;
  // Pool sizes for the random traffic
  localparam int N_SETS = 8;
  localparam int N_TAGS = 5;
  localparam int N_MIX  = 300;
  localparam int N_HOLD = 8;
  // Clearing, miss lookups, then the directed and random tests
  localparam int NUM_REQS = N_SETS * N_TAGS + N_SETS + 5 + 4 + 5 + 7 + N_HOLD + N_MIX;
  localparam int TIMEOUT_CYCLES = NUM_REQS * 10 + RESET_CYCLES;

  logic      CLK;
  logic      reset;
  logic      req;
  tag_req_t  req_data;
  logic      ack;
  tag_resp_t resp;

  `include "tag_array_checks.svh"

  // Random pools, distinct entries
  logic [INDEX_W-1:0] pool_sets [N_SETS];
  logic [TAG_W-1:0]   pool_tags [N_TAGS];
  logic [31:0]        lfsr_state = 32'h285e;

  // Finished requests for the compare process
  tag_req_t  req_queue  [$];
  tag_resp_t resp_queue [$];
  event      resp_ready;

  int cycle_count     = 0;
  int test_count      = 0;
  int checks_at_start = 0;
  int errors_at_start = 0;

  tag_array_top uut (
    .CLK      (CLK),
    .reset    (reset),
    .req      (req),
    .req_data (req_data),
    .ack      (ack),
    .resp     (resp)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic tag_op_t rand_op();
    logic [31:0] v;
    v = rand_bits(2);
    // Code 3 is unused, folded onto lookup
    if (v[1:0] == 2'd3) begin
      return OP_LOOKUP;
    end
    return tag_op_t'(v[1:0]);
  endfunction

  task automatic pick_pools();
    logic [31:0] v;
    logic        dup;
    for (int i = 0; i < N_SETS; i++) begin
      do begin
        v   = rand_bits(INDEX_W);
        dup = 1'b0;
        for (int j = 0; j < i; j++) begin
          if (pool_sets[j] == v[INDEX_W-1:0]) dup = 1'b1;
        end
      end while (dup);
      pool_sets[i] = v[INDEX_W-1:0];
    end
    for (int i = 0; i < N_TAGS; i++) begin
      do begin
        v   = rand_bits(TAG_W);
        dup = 1'b0;
        for (int j = 0; j < i; j++) begin
          if (pool_tags[j] == v[TAG_W-1:0]) dup = 1'b1;
        end
      end while (dup);
      pool_tags[i] = v[TAG_W-1:0];
    end
  endtask

  // Full four-phase transfer, req held for extra cycles after ack
  task automatic issue(input tag_op_t op, input logic [TAG_W-1:0] tag,
                       input logic [INDEX_W-1:0] index, input int hold,
                       output tag_resp_t got);
    tag_req_t r;
    r.op    = op;
    r.tag   = tag;
    r.index = index;
    @(posedge CLK);
    req      <= 1'b1;
    req_data <= r;
    @(posedge CLK);
    while (!ack) @(posedge CLK);
    got = resp;
    // Back-pressure, ack and resp must not move
    repeat (hold) begin
      @(posedge CLK);
      check_ack(1'b1, ack, "ack while req held");
      check_resp(got, resp, "resp while req held");
    end
    req <= 1'b0;
    @(posedge CLK);
    // Edge that sees req low, ack still up before it
    check_ack(1'b1, ack, "ack before req fall seen");
    @(posedge CLK);
    // Dropped on the edge that saw req low
    check_ack(1'b0, ack, "ack one edge after req fall");
    while (ack) @(posedge CLK);
    req_queue.push_back(r);
    resp_queue.push_back(got);
    -> resp_ready;
  endtask

  task automatic end_test(input string name);
    @(posedge CLK);
    test_count++;
    $display("%s: %0d checks, %0d errors", name,
             check_count - checks_at_start, error_count - errors_at_start);
    checks_at_start = check_count;
    errors_at_start = error_count;
  endtask

  // Compare every response against the reference
  initial begin
    tag_req_t  r;
    tag_resp_t act;
    tag_resp_t exp_resp;
    tag_op_t   op;
    forever begin
      @(resp_ready);
      while (resp_queue.size() > 0) begin
        r        = req_queue.pop_front();
        act      = resp_queue.pop_front();
        op       = r.op;
        exp_resp = ref_apply(r);
        check_resp(exp_resp, act,
                   $sformatf("%s tag %h set %0d", op.name(), r.tag, r.index));
      end
    end
  end

  // Run limit from the request count
  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, a req/ack handshake never completed", cycle_count);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    tag_resp_t   got;
    logic [31:0] v;
    int          si;
    int          ti;
    int          hold;
    reset    = 1'b1;
    req      = 1'b0;
    req_data = '0;
    foreach (model_sets[i]) model_sets[i] = '0;
    pick_pools();

    repeat (RESET_CYCLES) @(posedge CLK);
    reset <= 1'b0;
    @(posedge CLK);
    check_ack(1'b0, ack, "ack after reset");
    end_test("reset");

    // Clear the pool sets, then random lookups all miss
    for (int s = 0; s < N_SETS; s++) begin
      for (int t = 0; t < N_TAGS; t++) begin
        issue(OP_INVAL, pool_tags[t], pool_sets[s], 0, got);
      end
    end
    for (int s = 0; s < N_SETS; s++) begin
      v = rand_bits(TAG_W);
      issue(OP_LOOKUP, v[TAG_W-1:0], pool_sets[s], 0, got);
      check_hit(1'b0, got.hit, "lookup after invalidate");
    end
    end_test("invalidate_miss");

    // Empty set fills way 0 then way 1
    issue(OP_FILL, pool_tags[0], pool_sets[0], 0, got);
    check_way(1'b0, got.way, "first fill");
    issue(OP_FILL, pool_tags[1], pool_sets[0], 0, got);
    check_way(1'b1, got.way, "second fill");
    issue(OP_LOOKUP, pool_tags[0], pool_sets[0], 0, got);
    check_hit(1'b1, got.hit, "lookup first tag");
    check_way(1'b0, got.way, "lookup first tag");
    issue(OP_LOOKUP, pool_tags[1], pool_sets[0], 0, got);
    check_hit(1'b1, got.hit, "lookup second tag");
    check_way(1'b1, got.way, "lookup second tag");
    issue(OP_LOOKUP, pool_tags[2], pool_sets[0], 0, got);
    check_hit(1'b0, got.hit, "lookup third tag");
    end_test("fill_then_hit");

    // Full set, no eviction yet so the pointer is still 0
    issue(OP_FILL, pool_tags[2], pool_sets[0], 0, got);
    check_hit(1'b0, got.hit, "evicting fill");
    check_way(1'b0, got.way, "first eviction");
    for (int k = 1; k < 4; k++) begin
      issue(OP_FILL, pool_tags[(2 + k) % N_TAGS], pool_sets[0], 0, got);
      // Pointer flips on every evicting fill
      check_way(k[0], got.way, "victim alternates");
    end
    end_test("eviction");

    // Refill of a present tag
    issue(OP_FILL, pool_tags[0], pool_sets[1], 0, got);
    issue(OP_FILL, pool_tags[1], pool_sets[1], 0, got);
    issue(OP_FILL, pool_tags[0], pool_sets[1], 0, got);
    check_hit(1'b1, got.hit, "refill present tag");
    check_way(1'b0, got.way, "refill present tag");
    issue(OP_LOOKUP, pool_tags[0], pool_sets[1], 0, got);
    check_way(1'b0, got.way, "lookup after refill");
    issue(OP_LOOKUP, pool_tags[1], pool_sets[1], 0, got);
    check_hit(1'b1, got.hit, "other way after refill");
    end_test("fill_present");

    // Clearing way 0 leaves way 1 alone
    issue(OP_FILL, pool_tags[0], pool_sets[2], 0, got);
    issue(OP_FILL, pool_tags[1], pool_sets[2], 0, got);
    issue(OP_INVAL, pool_tags[0], pool_sets[2], 0, got);
    check_hit(1'b1, got.hit, "invalidate way 0");
    issue(OP_LOOKUP, pool_tags[1], pool_sets[2], 0, got);
    check_hit(1'b1, got.hit, "way 1 survives");
    check_way(1'b1, got.way, "way 1 survives");
    issue(OP_LOOKUP, pool_tags[0], pool_sets[2], 0, got);
    check_hit(1'b0, got.hit, "cleared tag gone");
    issue(OP_FILL, pool_tags[2], pool_sets[2], 0, got);
    check_way(1'b0, got.way, "freed way reused");
    issue(OP_LOOKUP, pool_tags[2], pool_sets[2], 0, got);
    check_way(1'b0, got.way, "lookup reused way");
    end_test("lane_isolation");

    // Requester holds req past ack
    for (int n = 0; n < N_HOLD; n++) begin
      si   = int'(rand_bits(3));
      ti   = int'(rand_bits(3)) % N_TAGS;
      hold = 1 + int'(rand_bits(2));
      issue(rand_op(), pool_tags[ti], pool_sets[si], hold, got);
    end
    end_test("handshake_hold");

    for (int n = 0; n < N_MIX; n++) begin
      si = int'(rand_bits(3));
      ti = int'(rand_bits(3)) % N_TAGS;
      issue(rand_op(), pool_tags[ti], pool_sets[si], 0, got);
    end
    end_test("random_mix");

    $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tag_array.f
+incdir+tests
design/tag_pkg.sv
design/fpga_ram.sv
design/spsram_512x22.sv
design/tag_lookup_ctrl.sv
design/tag_array_top.sv
tests/tag_array_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the tag array testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -f build.log sim.log

verilator --binary --assert -j 0 --top-module tag_array_tb -f tag_array.f \
  -o tag_array_sim > build.log 2>&1 \
  && ./obj_dir/tag_array_sim > sim.log 2>&1 \
  || { echo "Build or run error, see build.log and sim.log"; exit 1; }

grep -q "^Test passed$" sim.log \
  && echo "Simulation PASS" \
  || { echo "Simulation FAIL, see sim.log"; exit 1; }
